//--- common/port_map_pkg.sv
package port_map_pkg;

	//////////////////////////////
	// z80 i/o port numbers, low byte
	localparam logic [7:0] PORT_FE  = 8'hFE;	// beeper, border, keys
	localparam logic [7:0] PORT_FD  = 8'hFD;	// 7ffd paging
	localparam logic [7:0] PORT_F7  = 8'hF7;	// eff7, outside shadow only
	localparam logic [7:0] COVOX_FB = 8'hFB;
	localparam logic [7:0] COVOX_DD = 8'hDD;
	localparam logic [7:0] SDRV_0F  = 8'h0F;	// soundrive channel 0
	localparam logic [7:0] SDRV_1F  = 8'h1F;
	localparam logic [7:0] SDRV_4F  = 8'h4F;
	localparam logic [7:0] SDRV_5F  = 8'h5F;	// soundrive channel 3

	// nemo ide
	localparam logic [7:0] IDE_LO = 8'h10;	// data, low byte
	localparam logic [7:0] IDE_HI = 8'h11;	// data, high byte
	localparam logic [7:0] IDE_30 = 8'h30;
	localparam logic [7:0] IDE_50 = 8'h50;
	localparam logic [7:0] IDE_70 = 8'h70;
	localparam logic [7:0] IDE_90 = 8'h90;
	localparam logic [7:0] IDE_B0 = 8'hB0;
	localparam logic [7:0] IDE_D0 = 8'hD0;
	localparam logic [7:0] IDE_F0 = 8'hF0;
	localparam logic [7:0] IDE_C8 = 8'hC8;	// control block, cs1

	// xt register file, full 16-bit decode
	localparam logic [15:0] XT_ADDR_PORT = 16'h55FF;
	localparam logic [15:0] XT_DATA_PORT = 16'h56FF;

	localparam logic [7:0] XT_BORDER  = 8'h00;
	localparam logic [7:0] XT_VCONFIG = 8'h08;
	localparam logic [7:0] XT_PALADDR = 8'h09;
	localparam logic [7:0] XT_PALDATA = 8'h0A;
	localparam logic [7:0] XT_HCONFIG = 8'h1C;

	// one decoded i/o access, flags are combinational from the address
	typedef struct packed {
		logic fe;
		logic fd;
		logic f7;		// gated off in shadow mode
		logic covox;
		logic sdrv;		// gated off in shadow mode
		logic ide_lo;
		logic ide_hi;
		logic ide_reg;	// device ports other than #10
		logic ide_cs1;
		logic xt_addr;
		logic xt_data;
		logic wr;		// one-cycle write strobe
		logic rd;		// one-cycle read strobe
	} port_access_t;

endpackage

//--- common/cfg_pkg.sv
package cfg_pkg;

	localparam int BORDER_W = 6;
	localparam int DAC_W    = 6;

	//////////////////////////////
	// memory paging, raw port bytes
	typedef struct packed {
		logic [7:0] p7ffd;	// 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 1m page
		logic [7:0] peff7;	// 2 block1m, 3 ram0 at 0000
	} paging_t;

	localparam paging_t PAGING_RST = '{
		p7ffd: 8'h00,
		peff7: 8'h00
	};

	// four dac channels, left pair then right pair
	typedef struct packed {
		logic [DAC_W-1:0] psd3;
		logic [DAC_W-1:0] psd2;
		logic [DAC_W-1:0] psd1;
		logic [DAC_W-1:0] psd0;
	} sound_t;

	localparam sound_t SOUND_RST = '0;

	// video side of the xt registers
	typedef struct packed {
		logic [7:0]          vcfg;
		logic                hus_en;
		logic                li_en;
		logic [BORDER_W-1:0] border;
	} video_cfg_t;

	localparam video_cfg_t VIDEO_RST = '{
		vcfg:   8'h00,
		hus_en: 1'b0,
		li_en:  1'b0,
		border: '0
	};

endpackage

//--- design/bus_cycle.sv
`timescale 1ns/1ps

module bus_cycle (
	input  logic                       zclk,
	input  logic                       rst_n,
	input  logic [15:0]                a,
	input  logic                       iorq_n,
	input  logic                       rd_n,
	input  logic                       wr_n,
	input  logic                       dos,
	output port_map_pkg::port_access_t access
);
	import port_map_pkg::*;

	logic       iowr_q;		// last sample of the write qualifier
	logic       iord_q;
	logic       port_wr;
	logic       port_rd;
	logic [7:0] loa;

	assign loa = a[7:0];

	// one-zclk strobe from an edge on the sampled cycle
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_q  <= 1'b0;
			iord_q  <= 1'b0;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			iowr_q  <= ~(iorq_n | wr_n);
			iord_q  <= ~(iorq_n | rd_n);
			port_wr <= ~iowr_q & ~(iorq_n | wr_n);
			port_rd <= ~iord_q & ~(iorq_n | rd_n);
		end
	end

	//////////////////////////////
	// port decode
	always_comb
	begin
		access         = '0;
		access.fe      = (loa == PORT_FE);
		access.fd      = (loa == PORT_FD);
		access.f7      = (loa == PORT_F7) && !dos;
		access.covox   = (loa == COVOX_FB) || (loa == COVOX_DD);
		access.sdrv    = (loa inside {SDRV_0F, SDRV_1F, SDRV_4F, SDRV_5F}) && !dos;
		access.ide_lo  = (loa == IDE_LO);
		access.ide_hi  = (loa == IDE_HI);
		access.ide_reg = loa inside {IDE_30, IDE_50, IDE_70, IDE_90,
			IDE_B0, IDE_D0, IDE_F0, IDE_C8};
		access.ide_cs1 = (loa == IDE_C8);
		access.xt_addr = (a == XT_ADDR_PORT);
		access.xt_data = (a == XT_DATA_PORT);
		access.wr      = port_wr;
		access.rd      = port_rd;
	end

	// a bus cycle never reads and writes at once
	a_no_rd_wr: assert property (@(posedge zclk) disable iff (!rst_n)
		!(access.wr && access.rd));

endmodule

//--- ide/ide_bridge.sv
`timescale 1ns/1ps

module ide_bridge (
	input  logic                       zclk,
	input  logic                       rst_n,
	input  port_map_pkg::port_access_t access,
	input  logic [7:0]                 din,
	input  logic [15:0]                a,
	input  logic                       iorq_n,
	input  logic                       rd_n,
	input  logic                       wr_n,
	input  logic [15:0]                idein,
	output logic [15:0]                ideout,
	output logic [2:0]                 ide_a,
	output logic                       ide_cs0_n,
	output logic                       ide_cs1_n,
	output logic                       ide_rd_n,
	output logic                       ide_wr_n,
	output logic                       idedataout,
	output logic [7:0]                 ide_rdata
);
	logic        ide_ports;		// ports going to the device, #11 excluded
	logic        ide_touch;		// any ide access strobe, #11 included
	logic        rd_trig;		// nemo-divide read trigger
	logic        wrlo_trig;
	logic        wrhi_trig;
	logic        rd_latch;		// trigger frozen for the whole bus cycle
	logic        wrlo_latch;
	logic        wrhi_latch;
	logic [15:0] wr_hold;		// first half of a 16-bit write
	logic [7:0]  rd_hi;			// high byte kept from the low read

	assign ide_ports = access.ide_lo | access.ide_reg;
	assign ide_touch = (ide_ports | access.ide_hi) & (access.rd | access.wr);

	//////////////////////////////
	// triggers
	// normal read  #10 lo, #11 hi   divide read  #10 lo, #10 hi
	// normal write #11 hi, #10 lo   divide write #10 lo, #10 hi
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			rd_trig <= 1'b0;
		else if (access.ide_lo && access.rd && !rd_trig)
			rd_trig <= 1'b1;
		else if (ide_touch)
			rd_trig <= 1'b0;
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wrhi_trig <= 1'b0;
			wrlo_trig <= 1'b0;
		end
		else if (ide_touch)
		begin
			wrhi_trig <= access.ide_hi & access.wr;
			wrlo_trig <= access.ide_lo & access.wr & ~wrhi_trig & ~wrlo_trig;
		end
	end

	// triggers move mid-cycle, so the strobes look at a copy taken while idle
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_latch   <= 1'b0;
			wrlo_latch <= 1'b0;
			wrhi_latch <= 1'b0;
		end
		else
		begin
			if (rd_n)
				rd_latch <= rd_trig;
			if (wr_n)
			begin
				wrlo_latch <= wrlo_trig;
				wrhi_latch <= wrhi_trig;
			end
		end
	end

	always_ff @(posedge zclk)
	begin
		if (access.wr && access.ide_hi)
			wr_hold[15:8] <= din;
		if (access.wr && access.ide_lo && !wrlo_trig)
			wr_hold[7:0] <= din;
		if (access.rd && access.ide_lo && !rd_trig)
			rd_hi <= idein[15:8];	// low byte goes straight to the cpu
	end

	//////////////////////////////
	// device side
	assign ide_a     = a[7:5];
	assign ide_cs0_n = ~(ide_ports & ~access.ide_cs1);
	assign ide_cs1_n = ~access.ide_cs1;

	// no device strobe on the first half of a pair
	assign ide_rd_n = iorq_n | rd_n | ~ide_ports | (rd_latch & access.ide_lo);
	assign ide_wr_n = iorq_n | wr_n | ~ide_ports |
		(access.ide_lo & ~wrlo_latch & ~wrhi_latch);

	assign idedataout = ide_rd_n;

	assign ideout[15:8] = wrhi_latch ? wr_hold[15:8] : din;
	assign ideout[7:0]  = wrlo_latch ? wr_hold[7:0] : din;

	assign ide_rdata = (access.ide_hi || (rd_latch && access.ide_lo)) ? rd_hi : idein[7:0];

	a_ide_dir: assert property (@(posedge zclk) disable iff (!rst_n)
		!(!ide_rd_n && !ide_wr_n));

endmodule

//--- design/mem_pager.sv
`timescale 1ns/1ps

module mem_pager (
	input  logic                       zclk,
	input  logic                       rst_n,
	input  port_map_pkg::port_access_t access,
	input  logic [7:0]                 din,
	input  logic [15:0]                a,
	input  logic [1:0]                 rstrom,
	output cfg_pkg::paging_t           paging,
	output logic [7:0]                 p7ffd,
	output logic [7:0]                 peff7,
	output logic [5:0]                 pent1m_page,
	output logic                       pent1m_rom,
	output logic                       pent1m_1m_on,
	output logic                       pent1m_ram0_0
);
	import cfg_pkg::*;

	logic [2:0] ext_q;		// 7ffd bits 7..5
	logic [3:0] scr_q;		// 7ffd bits 3..0
	logic       rom_q;
	logic [7:0] eff7_q;
	logic [1:0] rst_sync;
	logic       block1m;
	logic       block7ffd;
	logic       fd_wr;
	logic [7:0] p7ffd_raw;

	assign block1m   = eff7_q[2];
	assign block7ffd = ext_q[0] & block1m;	// bit 5 locks only with block1m
	assign fd_wr     = access.fd & access.wr & ~a[15] & ~block7ffd;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			rst_sync <= 2'b11;
		else
			rst_sync <= {rst_sync[0], 1'b0};
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ext_q  <= PAGING_RST.p7ffd[7:5];
			scr_q  <= PAGING_RST.p7ffd[3:0];
			eff7_q <= PAGING_RST.peff7;
		end
		else
		begin
			if (fd_wr)
			begin
				ext_q <= din[7:5];
				scr_q <= din[3:0];
			end
			if (access.f7 && access.wr && !a[12])
				eff7_q <= din;
		end
	end

	// rom select follows the boot choice until the sync drops
	always_ff @(posedge zclk)
	begin
		if (rst_sync[1])
			rom_q <= rstrom[0];
		else if (fd_wr)
			rom_q <= din[4];
	end

	assign p7ffd_raw = {ext_q, rom_q, scr_q};

	assign paging.p7ffd = p7ffd_raw;
	assign paging.peff7 = eff7_q;

	assign p7ffd = {(block1m ? 3'b000 : ext_q), rom_q, scr_q};
	assign peff7 = block1m ? {eff7_q[7], 1'b0, eff7_q[5:4], 3'b000, eff7_q[0]} : eff7_q;

	assign pent1m_page   = {ext_q, scr_q[2:0]};
	assign pent1m_rom    = rom_q;
	assign pent1m_1m_on  = ~eff7_q[2];
	assign pent1m_ram0_0 = eff7_q[3];

endmodule

//--- design/sound_border.sv
`timescale 1ns/1ps

module sound_border (
	input  logic                         zclk,
	input  logic                         rst_n,
	input  port_map_pkg::port_access_t   access,
	input  logic [7:0]                   din,
	input  logic [15:0]                  a,
	output logic [cfg_pkg::DAC_W-1:0]    psd0,
	output logic [cfg_pkg::DAC_W-1:0]    psd1,
	output logic [cfg_pkg::DAC_W-1:0]    psd2,
	output logic [cfg_pkg::DAC_W-1:0]    psd3,
	output logic [cfg_pkg::BORDER_W-1:0] border,
	output logic [7:0]                   vcfg,
	output logic [7:0]                   sp_wa,
	output logic                         sp_we,
	output logic                         hus_en,
	output logic                         li_en
);
	import port_map_pkg::*;
	import cfg_pkg::*;

	sound_t     snd_q;
	video_cfg_t vid_q;
	logic [7:0] xt_idx;		// selected xt register
	logic       fe_wr;
	logic       dac_wr;
	logic       xt_reg_wr;

	assign fe_wr     = access.fe & access.wr;
	assign dac_wr    = (access.covox | access.sdrv) & access.wr;
	assign xt_reg_wr = access.xt_data & access.wr;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			snd_q  <= SOUND_RST;
			vid_q  <= VIDEO_RST;
			xt_idx <= 8'h00;
		end
		else
		begin
			if (access.xt_addr && access.wr)
				xt_idx <= din;

			//////////////////////////////
			// beeper and tape out on all channels
			if (fe_wr)
			begin
				snd_q.psd0   <= {DAC_W{din[4]}};
				snd_q.psd1   <= {DAC_W{din[4]}};
				snd_q.psd2   <= {din[4], {(DAC_W - 1){din[3]}}};
				snd_q.psd3   <= {DAC_W{din[3]}};
				vid_q.border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0};
			end

			if (dac_wr)
			begin
				if (access.covox)
					snd_q <= {4{din[7:2]}};	// covox drives every channel
				else
					case (a[7:0])
						SDRV_0F: snd_q.psd0 <= din[7:2];
						SDRV_1F: snd_q.psd1 <= din[7:2];
						SDRV_4F: snd_q.psd2 <= din[7:2];
						SDRV_5F: snd_q.psd3 <= din[7:2];
						default: ;
					endcase
			end

			if (xt_reg_wr)
				case (xt_idx)
					XT_BORDER:  vid_q.border <= din[BORDER_W-1:0];	// overrides fe
					XT_VCONFIG: vid_q.vcfg   <= din;
					XT_HCONFIG:
					begin
						vid_q.hus_en <= din[7];
						vid_q.li_en  <= din[6];
					end
					default: ;
				endcase
		end
	end

	// palette address
	always_ff @(posedge zclk)
	begin
		if (xt_reg_wr && xt_idx == XT_PALADDR)
			sp_wa <= din;
	end

	assign sp_we = xt_reg_wr & (xt_idx == XT_PALDATA);	// data itself on din

	assign psd0   = snd_q.psd0;
	assign psd1   = snd_q.psd1;
	assign psd2   = snd_q.psd2;
	assign psd3   = snd_q.psd3;
	assign border = vid_q.border;
	assign vcfg   = vid_q.vcfg;
	assign hus_en = vid_q.hus_en;
	assign li_en  = vid_q.li_en;

endmodule

//--- design/read_mux.sv
`timescale 1ns/1ps

module read_mux (
	input  port_map_pkg::port_access_t access,
	input  logic [15:0]                a,
	input  logic                       iorq_n,
	input  logic                       rd_n,
	input  logic                       dos,
	input  logic [4:0]                 keys_in,
	input  logic                       tape_read,
	input  cfg_pkg::paging_t           paging,
	input  logic [7:0]                 ide_rdata,
	output logic [7:0]                 dout,
	output logic                       dataout,
	output logic                       porthit
);
	logic ide_hit;

	assign ide_hit = access.ide_lo | access.ide_hi | access.ide_reg;

	always_comb
	begin
		if (access.fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (ide_hit)
			dout = ide_rdata;
		else if (access.f7 && !a[12])
			dout = paging.peff7;	// eff7 readback
		else
			dout = 8'hFF;
	end

	//////////////////////////////
	// internal port claim, drives the zxbus iorq split
	assign porthit = access.fe | access.fd | access.covox | ide_hit |
		access.xt_addr | access.xt_data |
		((access.f7 | access.sdrv) & ~dos);	// these belong to tr-dos in shadow

	assign dataout = porthit & ~iorq_n & ~rd_n;

endmodule

//--- design/zports_top.sv
`timescale 1ns/1ps

module zports_top (
	input  logic                         zclk,
	input  logic                         rst_n,
	input  logic [15:0]                  a,
	input  logic [7:0]                   din,
	input  logic                         iorq_n,
	input  logic                         rd_n,
	input  logic                         wr_n,
	input  logic                         dos,
	input  logic [1:0]                   rstrom,
	input  logic [4:0]                   keys_in,
	input  logic                         tape_read,
	input  logic [15:0]                  idein,
	output logic [7:0]                   dout,
	output logic                         dataout,
	output logic                         porthit,
	output logic [15:0]                  ideout,
	output logic [2:0]                   ide_a,
	output logic                         ide_cs0_n,
	output logic                         ide_cs1_n,
	output logic                         ide_rd_n,
	output logic                         ide_wr_n,
	output logic                         idedataout,
	output logic [7:0]                   p7ffd,
	output logic [7:0]                   peff7,
	output logic [5:0]                   pent1m_page,
	output logic                         pent1m_rom,
	output logic                         pent1m_1m_on,
	output logic                         pent1m_ram0_0,
	output logic [cfg_pkg::DAC_W-1:0]    psd0,
	output logic [cfg_pkg::DAC_W-1:0]    psd1,
	output logic [cfg_pkg::DAC_W-1:0]    psd2,
	output logic [cfg_pkg::DAC_W-1:0]    psd3,
	output logic [cfg_pkg::BORDER_W-1:0] border,
	output logic [7:0]                   vcfg,
	output logic [7:0]                   sp_wa,
	output logic                         sp_we,
	output logic                         hus_en,
	output logic                         li_en
);
	import port_map_pkg::*;
	import cfg_pkg::*;

	port_access_t access;
	paging_t      paging;
	logic [7:0]   ide_rdata;

	bus_cycle u_bus_cycle (.zclk(zclk), .rst_n(rst_n), .a(a), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .dos(dos), .access(access));

	ide_bridge u_ide_bridge (.zclk(zclk), .rst_n(rst_n), .access(access), .din(din),
		.a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .idein(idein),
		.ideout(ideout), .ide_a(ide_a), .ide_cs0_n(ide_cs0_n), .ide_cs1_n(ide_cs1_n),
		.ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n), .idedataout(idedataout),
		.ide_rdata(ide_rdata));

	mem_pager u_mem_pager (.zclk(zclk), .rst_n(rst_n), .access(access), .din(din),
		.a(a), .rstrom(rstrom), .paging(paging), .p7ffd(p7ffd), .peff7(peff7),
		.pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0));

	sound_border u_sound_border (.zclk(zclk), .rst_n(rst_n), .access(access),
		.din(din), .a(a), .psd0(psd0), .psd1(psd1), .psd2(psd2), .psd3(psd3),
		.border(border), .vcfg(vcfg), .sp_wa(sp_wa), .sp_we(sp_we),
		.hus_en(hus_en), .li_en(li_en));

	read_mux u_read_mux (.access(access), .a(a), .iorq_n(iorq_n), .rd_n(rd_n),
		.dos(dos), .keys_in(keys_in), .tape_read(tape_read), .paging(paging),
		.ide_rdata(ide_rdata), .dout(dout), .dataout(dataout), .porthit(porthit));

endmodule

//--- bench/tb_zports.sv
`timescale 1ns/1ps

module tb_zports;

	localparam int HALF_PERIOD = 10;	// 20 ns zclk
	localparam int DRIVE_DLY   = 1;
	localparam int MAX_OPS     = 64;

	localparam logic [4:0] KEYS = 5'h15;
	localparam logic       TAPE = 1'b1;

	// operation codes of the pattern file
	localparam logic [7:0] OP_WRITE  = 8'h00;
	localparam logic [7:0] OP_READ   = 8'h01;	// checks {dataout, dout}
	localparam logic [7:0] OP_BORDER = 8'h02;
	localparam logic [7:0] OP_P7FFD  = 8'h03;
	localparam logic [7:0] OP_PEFF7  = 8'h04;
	localparam logic [7:0] OP_PSD    = 8'h05;	// {psd3, psd2, psd1, psd0}
	localparam logic [7:0] OP_VCFG   = 8'h06;
	localparam logic [7:0] OP_IDE_WR = 8'h07;	// write with ideout seen while ide_wr_n low
	localparam logic [7:0] OP_DOS    = 8'h08;

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [1:0]  rstrom;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [15:0] idein;

	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [15:0] ideout;
	logic [2:0]  ide_a;
	logic        ide_cs0_n, ide_cs1_n, ide_rd_n, ide_wr_n, idedataout;
	logic [7:0]  p7ffd, peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic [5:0]  psd0, psd1, psd2, psd3, border;
	logic [7:0]  vcfg, sp_wa;
	logic        sp_we, hus_en, li_en;

	logic [23:0] pat [0:MAX_OPS*5-1];	// five words per operation
	logic [7:0]  lfsr;
	logic [7:0]  seen_dout;
	logic        seen_dataout;
	logic        seen_porthit;
	logic [15:0] seen_ideout;
	logic        seen_wr_low;
	logic [2:0]  seen_ide_a;
	logic        seen_cs0_n;
	logic        seen_cs1_n;
	int          n_ops         = 0;
	int          n_checks      = 0;
	int          mismatches    = 0;
	int          other_errs    = 0;
	int          cycle_cnt     = 0;
	int          timeout_limit = 0;

	zports_top DUT (.*);

	always #(HALF_PERIOD) zclk = ~zclk;

	//////////////////////////////
	// watchdog
	always @(posedge zclk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (timeout_limit > 0 && cycle_cnt >= timeout_limit)
		begin
			other_errs = other_errs + 1;
			$display("timeout, run still busy after %0d cycles", timeout_limit);
			$display("checks %0d, mismatches %0d, other errors %0d",
				n_checks, mismatches, other_errs);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		if (s[0])
			return (s >> 1) ^ 8'hB8;	// x^8 + x^6 + x^5 + x^4 + 1
		else
			return s >> 1;
	endfunction

	task automatic report_mismatch(input string name, input logic [23:0] exp_val,
		input logic [23:0] act_val);
		mismatches = mismatches + 1;
		$display("MISMATCH %s expected %0h got %0h at %0t", name, exp_val, act_val, $time);
	endtask

	// 1 to 4 idle cycles from two lfsr bits
	task automatic idle_gap;
		int gap;
		gap = 1;
		for (int b = 0; b < 2; b++)
		begin
			if (lfsr[0])
				gap = gap + (1 << b);
			lfsr = lfsr_next(lfsr);
		end
		repeat (gap - 1) @(posedge zclk);
	endtask

	//////////////////////////////
	// one z80 i/o cycle with the qualifiers low for 3 clocks
	task automatic io_cycle(input logic is_read, input logic [15:0] addr,
		input logic [7:0] data, input logic [15:0] ide_in);
		@(posedge zclk);
		#DRIVE_DLY;
		a      = addr;
		din    = data;
		idein  = ide_in;
		iorq_n = 1'b0;
		rd_n   = ~is_read;
		wr_n   = is_read;
		repeat (2) @(posedge zclk);
		@(negedge zclk);	// last clock of the access
		seen_dout    = dout;
		seen_dataout = dataout;
		seen_porthit = porthit;
		seen_ideout  = ideout;
		seen_wr_low  = ~ide_wr_n;
		seen_ide_a   = ide_a;
		seen_cs0_n   = ide_cs0_n;
		seen_cs1_n   = ide_cs1_n;
		@(posedge zclk);
		#DRIVE_DLY;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		idle_gap();
	endtask

	task automatic check_reg(input logic [7:0] op, input logic [23:0] exp_val);
		@(negedge zclk);
		n_checks = n_checks + 1;
		case (op)
			OP_BORDER:
				if (border !== exp_val[5:0])
					report_mismatch("border", exp_val, border);
			OP_P7FFD:
			begin
				if (p7ffd !== exp_val[7:0])
					report_mismatch("p7ffd", exp_val, p7ffd);
				if (pent1m_rom !== exp_val[4])	// rom bit is never masked
					report_mismatch("pent1m_rom", exp_val[4], pent1m_rom);
			end
			OP_PEFF7:
				if (peff7 !== exp_val[7:0])
					report_mismatch("peff7", exp_val, peff7);
			OP_PSD:
				if ({psd3, psd2, psd1, psd0} !== exp_val)
					report_mismatch("psd3..psd0", exp_val, {psd3, psd2, psd1, psd0});
			default:
				if (vcfg !== exp_val[7:0])
					report_mismatch("vcfg", exp_val, vcfg);
		endcase
	endtask

	task automatic run_op(input logic [7:0] op, input logic [15:0] addr, input logic [7:0] data,
		input logic [15:0] ide_in, input logic [23:0] exp_val);
		case (op)
			OP_WRITE:
				io_cycle(1'b0, addr, data, ide_in);
			OP_READ:
			begin
				io_cycle(1'b1, addr, data, ide_in);
				n_checks = n_checks + 3;
				if (seen_dout !== exp_val[7:0])
					report_mismatch("dout", exp_val[7:0], seen_dout);
				if (seen_dataout !== exp_val[8])
					report_mismatch("dataout", exp_val[8], seen_dataout);
				if (seen_porthit !== exp_val[8])	// read is active, so hit equals dataout
					report_mismatch("porthit", exp_val[8], seen_porthit);
			end
			OP_IDE_WR:
			begin
				io_cycle(1'b0, addr, data, ide_in);
				n_checks = n_checks + 3;
				if (!seen_wr_low)
				begin
					other_errs = other_errs + 1;
					$display("ide_wr_n stayed high during the IDE write to port %h", addr);
				end
				else if (seen_ideout !== exp_val[15:0])
					report_mismatch("ideout", exp_val[15:0], seen_ideout);
				if (seen_ide_a !== addr[7:5])
					report_mismatch("ide_a", addr[7:5], seen_ide_a);
				// data port, command block select only
				if ({seen_cs1_n, seen_cs0_n} !== 2'b10)
					report_mismatch("ide_cs1_n,ide_cs0_n", 2'b10, {seen_cs1_n, seen_cs0_n});
			end
			OP_DOS:
			begin
				@(posedge zclk);
				#DRIVE_DLY dos = data[0];
			end
			OP_BORDER, OP_P7FFD, OP_PEFF7, OP_PSD, OP_VCFG:
				check_reg(op, exp_val);
			default:
			begin
				other_errs = other_errs + 1;
				$display("unknown operation code %h in the pattern file", op);
			end
		endcase
	endtask

	initial
	begin
		zclk      = 1'b0;
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		rstrom    = 2'b10;	// rom bit taken from bit 0 comes up 0
		keys_in   = KEYS;
		tape_read = TAPE;
		idein     = 16'h0000;
		lfsr      = 8'd48;
		$readmemh("bench/zports_patterns.hex", pat);
		while (n_ops < MAX_OPS && pat[n_ops*5] !== {24{1'bx}})
			n_ops = n_ops + 1;
		timeout_limit = n_ops * 10 + 50;
		repeat (4) @(posedge zclk);
		#DRIVE_DLY rst_n = 1'b1;
		if (n_ops == 0)
		begin
			other_errs = other_errs + 1;
			$display("pattern file is missing or holds no operations");
		end
		for (int i = 0; i < n_ops; i++)
			run_op(pat[i*5][7:0], pat[i*5+1][15:0], pat[i*5+2][7:0], pat[i*5+3][15:0],
				pat[i*5+4]);
		$display("checks %0d, mismatches %0d, other errors %0d", n_checks, mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- bench/zports_patterns.hex
// op addr data idein expect, op 00 wr 01 rd {dataout,dout} 02 border 03 p7ffd 04 peff7
// 05 {psd3,psd2,psd1,psd0} 06 vcfg 07 wr with ideout check 08 dos from data bit 0
06 0000 00 0000 000000
03 0000 00 0000 000000
04 0000 00 0000 000000
00 00FE 1B 0000 000000
02 0000 00 0000 000022
05 0000 00 0000 FFFFFF
01 00FE 00 0000 0001D5
00 00FB 80 0000 000000
05 0000 00 0000 820820
00 004F FC 0000 000000
05 0000 00 0000 83F820
00 000F 40 0000 000000
05 0000 00 0000 83F810
00 55FF 08 0000 000000
00 56FF 5A 0000 000000
06 0000 00 0000 00005A
00 55FF 00 0000 000000
00 56FF 15 0000 000000
02 0000 00 0000 000015
00 0011 AB 0000 000000
07 0010 CD 0000 00ABCD
00 0010 11 0000 000000
07 0010 22 0000 002211
01 0010 00 1234 000134
01 0010 00 1234 000112
01 0010 00 5678 000178
01 0011 00 5678 000156
00 7FFD 25 0000 000000
03 0000 00 0000 000025
00 EFF7 04 0000 000000
04 0000 00 0000 000000
03 0000 00 0000 000005
00 7FFD 12 0000 000000
03 0000 00 0000 000005
08 0000 01 0000 000000
01 EFF7 00 0000 0000FF
01 004F 00 0000 0000FF
00 EFF7 08 0000 000000
00 004F 00 0000 000000
04 0000 00 0000 000000
03 0000 00 0000 000005
05 0000 00 0000 83F810
08 0000 00 0000 000000
01 00FE 00 0000 0001D5

//--- sim.f
common/port_map_pkg.sv
common/cfg_pkg.sv
design/bus_cycle.sv
ide/ide_bridge.sv
design/mem_pager.sv
design/sound_border.sv
design/read_mux.sv
design/zports_top.sv
bench/tb_zports.sv
